/* logic/conv_pkg.sv */
package conv_pkg;

	// ------------------------------------------------------------------
	// frame geometry
	// ------------------------------------------------------------------

	// image edge in pixels
	localparam int IMG_DIM = 8;
	// taps in each separable pass
	localparam int TAPS = 5;
	// valid output edge after a 5-tap pass
	localparam int OUT_DIM = IMG_DIM - TAPS + 1;
	// row sums kept between the two passes, 8 rows of 4
	localparam int ROW_SUM_COUNT = IMG_DIM * OUT_DIM;
	// results per frame
	localparam int OUT_COUNT = OUT_DIM * OUT_DIM;

	// ------------------------------------------------------------------
	// sample types
	// ------------------------------------------------------------------

	// pixels and taps share one signed nibble
	typedef logic signed [3:0] sample_t;

	// five products of at most 64 each, so 10 bits is enough
	typedef logic signed [9:0] row_sum_t;

	// final column-pass result
	typedef logic signed [15:0] result_t;

endpackage

/* logic/filter_tap_loader.sv */
`timescale 1ns/10ps

module filter_tap_loader import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    filter_valid,
	input  sample_t in_data,
	output sample_t row_taps [TAPS],
	output sample_t col_taps [TAPS]
);

	// arrival count, 0..9 over one tap burst
	logic [3:0] tap_cnt;
	// slot within the column tap set
	logic [3:0] col_sel;

	assign col_sel = tap_cnt - 4'(TAPS);

	// ------------------------------------------------------------------
	// tap counter
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tap_cnt <= '0;
		end else if (!filter_valid) begin
			// any gap re-arms for the next burst
			tap_cnt <= '0;
		end else if (tap_cnt == 4'(2 * TAPS - 1)) begin
			tap_cnt <= '0;
		end else begin
			tap_cnt <= tap_cnt + 4'd1;
		end
	end

	// ------------------------------------------------------------------
	// tap registers
	// ------------------------------------------------------------------
	// first five arrivals go to the row set, next five to the column set
	// held across frames until the next burst overwrites them
	always_ff @(posedge clk) begin
		if (filter_valid) begin
			if (tap_cnt < 4'(TAPS)) begin
				row_taps[tap_cnt[2:0]] <= in_data;
			end else begin
				col_taps[col_sel[2:0]] <= in_data;
			end
		end
	end

endmodule

/* logic/horizontal_filter.sv */
`timescale 1ns/10ps

module horizontal_filter import conv_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     image_valid,
	input  sample_t  in_data,
	input  sample_t  row_taps [TAPS],
	output logic     row_sum_valid,
	output row_sum_t row_sum
);

	// four held pixels, oldest at index 0
	sample_t win [TAPS-1];
	// five-pixel view, the live pixel sits in the last slot
	sample_t pix [TAPS];
	// column of the pixel arriving this cycle
	logic [2:0] col_cnt;
	// full window inside one row
	logic win_full;

	// products stage
	logic signed [7:0] prod [TAPS];
	logic prod_valid;
	// adder tree output
	row_sum_t sum_c;

	// ------------------------------------------------------------------
	// pixel window and column count
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_cnt <= '0;
		end else if (image_valid) begin
			// wraps every 8 pixels
			col_cnt <= col_cnt + 3'd1;
		end else begin
			col_cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (image_valid) begin
			for (int k = 0; k < TAPS - 2; k++) begin
				win[k] <= win[k+1];
			end
			win[TAPS-2] <= in_data;
		end
	end

	always_comb begin
		for (int k = 0; k < TAPS - 1; k++) begin
			pix[k] = win[k];
		end
		pix[TAPS-1] = in_data;
	end

	// columns 4..7 close a window that started in the same row
	assign win_full = image_valid && (col_cnt >= 3'(TAPS - 1));

	// ------------------------------------------------------------------
	// stage 1, products
	// ------------------------------------------------------------------
	// tap k meets the pixel k columns right of the window start
	always_ff @(posedge clk) begin
		for (int k = 0; k < TAPS; k++) begin
			prod[k] <= pix[k] * row_taps[k];
		end
	end

	// ------------------------------------------------------------------
	// stage 2, sum
	// ------------------------------------------------------------------
	always_comb begin
		sum_c = '0;
		for (int k = 0; k < TAPS; k++) begin
			sum_c = sum_c + prod[k];
		end
	end

	always_ff @(posedge clk) begin
		row_sum <= sum_c;
	end

	// valid rides along with the data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prod_valid    <= 1'b0;
			row_sum_valid <= 1'b0;
		end else begin
			prod_valid    <= win_full;
			row_sum_valid <= prod_valid;
		end
	end

endmodule

/* logic/row_result_store.sv */
`timescale 1ns/10ps

module row_result_store import conv_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     row_sum_valid,
	input  row_sum_t row_sum,
	input  logic [1:0] rd_row,
	input  logic [1:0] rd_col,
	output logic     frame_ready,
	output row_sum_t rd_data [TAPS]
);

	// row sums, row-major, one row of 4 per image row
	row_sum_t mem [IMG_DIM][OUT_DIM];
	// next slot to fill, row in the upper bits
	logic [4:0] wr_idx;
	// last slot of the frame is being written
	logic last_wr;

	assign last_wr = row_sum_valid && (wr_idx == 5'(ROW_SUM_COUNT - 1));

	// ------------------------------------------------------------------
	// write side
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (row_sum_valid) begin
			mem[wr_idx[4:2]][wr_idx[1:0]] <= row_sum;
		end
	end

	// sums arrive in raster order, so a plain counter addresses them
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_idx <= '0;
		end else if (last_wr) begin
			// re-arm for the next frame
			wr_idx <= '0;
		end else if (row_sum_valid) begin
			wr_idx <= wr_idx + 5'd1;
		end
	end

	// one-cycle pulse once all 32 sums are in
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_ready <= 1'b0;
		end else begin
			frame_ready <= last_wr;
		end
	end

	// ------------------------------------------------------------------
	// read side
	// ------------------------------------------------------------------
	// vertical slice of five rows starting at rd_row, column rd_col
	// rd_row tops out at 3, so rd_row+4 stays inside the 8 rows
	always_ff @(posedge clk) begin
		for (int k = 0; k < TAPS; k++) begin
			rd_data[k] <= mem[{1'b0, rd_row} + 3'(k)][rd_col];
		end
	end

endmodule

/* logic/vertical_filter.sv */
`timescale 1ns/10ps

module vertical_filter import conv_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     frame_ready,
	input  row_sum_t rd_data [TAPS],
	input  sample_t  col_taps [TAPS],
	output logic [1:0] rd_row,
	output logic [1:0] rd_col,
	output logic     out_valid,
	output result_t  out_data
);

	// output position, raster order
	logic [3:0] pos;
	// run in progress after the first position
	logic busy;
	// a read position goes out this cycle
	logic issue;

	// valid at the store output and at the products register
	logic rd_valid;
	logic prod_valid;

	// row sum times column tap, 14 bits covers 320 * 8
	logic signed [13:0] prod [TAPS];
	result_t sum_c;

	// ------------------------------------------------------------------
	// position sequencer
	// ------------------------------------------------------------------
	// frame_ready itself issues position 0, so no idle cycle is lost
	assign issue = frame_ready || busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos  <= '0;
			busy <= 1'b0;
		end else begin
			if (issue) begin
				// wraps back to 0 after position 15
				pos <= pos + 4'd1;
			end
			busy <= issue && (pos != 4'(OUT_COUNT - 1));
		end
	end

	// upper bits pick the first row, lower bits the column
	assign rd_row = pos[3:2];
	assign rd_col = pos[1:0];

	// ------------------------------------------------------------------
	// multiply and sum
	// ------------------------------------------------------------------
	// rd_data[k] is row rd_row+k, matched to column tap k
	always_ff @(posedge clk) begin
		for (int k = 0; k < TAPS; k++) begin
			prod[k] <= rd_data[k] * col_taps[k];
		end
	end

	always_comb begin
		sum_c = '0;
		for (int k = 0; k < TAPS; k++) begin
			sum_c = sum_c + prod[k];
		end
	end

	// ------------------------------------------------------------------
	// valid pipeline and output register
	// ------------------------------------------------------------------
	// read, products, sum -> three stages, up to three results in flight
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_valid   <= 1'b0;
			prod_valid <= 1'b0;
			out_valid  <= 1'b0;
			out_data   <= '0;
		end else begin
			rd_valid   <= issue;
			prod_valid <= rd_valid;
			out_valid  <= prod_valid;
			// zero between results
			out_data   <= prod_valid ? sum_c : '0;
		end
	end

endmodule

/* logic/conv_top.sv */
`timescale 1ns/10ps

module conv_top import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    filter_valid,
	input  logic    image_valid,
	input  sample_t in_data,
	output logic    out_valid,
	output result_t out_data
);

	// tap sets
	sample_t row_taps [TAPS];
	sample_t col_taps [TAPS];

	// row pass to store
	logic     row_sum_valid;
	row_sum_t row_sum;

	// store to column pass
	logic       frame_ready;
	logic [1:0] rd_row;
	logic [1:0] rd_col;
	row_sum_t   rd_data [TAPS];

	// ------------------------------------------------------------------
	// tap capture
	// ------------------------------------------------------------------
	filter_tap_loader u_filter_tap_loader (
		.clk          (clk),
		.rst_n        (rst_n),
		.filter_valid (filter_valid),
		.in_data      (in_data),
		.row_taps     (row_taps),
		.col_taps     (col_taps)
	);

	// 1x5 pass over each image row
	horizontal_filter u_horizontal_filter (
		.clk           (clk),
		.rst_n         (rst_n),
		.image_valid   (image_valid),
		.in_data       (in_data),
		.row_taps      (row_taps),
		.row_sum_valid (row_sum_valid),
		.row_sum       (row_sum)
	);

	// ------------------------------------------------------------------
	// row sum buffer and 5x1 pass
	// ------------------------------------------------------------------
	row_result_store u_row_result_store (
		.clk           (clk),
		.rst_n         (rst_n),
		.row_sum_valid (row_sum_valid),
		.row_sum       (row_sum),
		.rd_row        (rd_row),
		.rd_col        (rd_col),
		.frame_ready   (frame_ready),
		.rd_data       (rd_data)
	);

	vertical_filter u_vertical_filter (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_ready (frame_ready),
		.rd_data     (rd_data),
		.col_taps    (col_taps),
		.rd_row      (rd_row),
		.rd_col      (rd_col),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

endmodule

/* test/conv_sva.sv */
`timescale 1ns/10ps

module conv_sva import conv_pkg::*; (
	input logic    clk,
	input logic    rst_n,
	input logic    filter_valid,
	input logic    image_valid,
	input logic    out_valid,
	input result_t out_data
);

	// length of the current out_valid run
	int unsigned run_len;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_len <= 0;
		end else if (out_valid) begin
			run_len <= run_len + 1;
		end else begin
			run_len <= 0;
		end
	end

	// ----------------------------------------------------------------------
	// output behavior
	// ----------------------------------------------------------------------
	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	a_zero_idle: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> out_data == '0)
		else $error("out_data nonzero while out_valid low");

	// run never longer than one frame of results
	a_run_max: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> run_len < OUT_COUNT)
		else $error("out_valid run longer than a frame");

	// and never shorter
	a_run_min: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(out_valid) |-> run_len == OUT_COUNT)
		else $error("out_valid run shorter than a frame");

	// input strobes are exclusive
	a_valid_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(filter_valid && image_valid))
		else $error("filter_valid and image_valid high together");

endmodule

bind conv_top conv_sva u_conv_sva (
	.clk          (clk),
	.rst_n        (rst_n),
	.filter_valid (filter_valid),
	.image_valid  (image_valid),
	.out_valid    (out_valid),
	.out_data     (out_data)
);

/* test/conv_tb.sv */
`timescale 1ns/10ps

module conv_tb import conv_pkg::*; ();

	// ----------------------------------------------------------------------
	// run constants
	// ----------------------------------------------------------------------
	localparam int CLK_HALF     = 50;
	localparam int DRIVE_DELAY  = 10;
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES  = 20;
	// identity, random, extremes, then three back to back
	localparam int FRAME_COUNT  = 6;
	localparam int WATCHDOG_NS  = (FRAME_COUNT * 120 + 100) * 100;
	// cycles allowed between the last pixel and the first result
	localparam int START_WAIT   = 40;

	logic    clk;
	logic    rst_n;
	logic    filter_valid;
	logic    image_valid;
	sample_t in_data;
	logic    out_valid;
	result_t out_data;

	// stimulus and expected results of the current frame
	int      pix_mem [IMG_DIM][IMG_DIM];
	int      row_tap [TAPS];
	int      col_tap [TAPS];
	result_t exp_res [OUT_COUNT];

	conv_top u_conv_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.filter_valid (filter_valid),
		.image_valid  (image_valid),
		.in_data      (in_data),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

	always #(CLK_HALF) clk = ~clk;

	// ----------------------------------------------------------------------
	// failure handling and compares
	// ----------------------------------------------------------------------
	task automatic stop_with_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_result(input string sig, input result_t exp_v, input result_t act_v);
		if (act_v !== exp_v) begin
			$display("** Error at %0t: %s expected %0d, got %0d", $time, sig, exp_v, act_v);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string sig, input bit exp_v, input bit act_v);
		if (act_v !== exp_v) begin
			$display("** Error at %0t: %s expected %0b, got %0b", $time, sig, exp_v, act_v);
			stop_with_failure();
		end
	endtask

	// watchdog, sized from the frame count
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		stop_with_failure();
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	// inputs change just after the rising edge
	task automatic drive_cycle(input logic fv, input logic iv, input int value);
		@(posedge clk);
		#(DRIVE_DELAY);
		filter_valid = fv;
		image_valid  = iv;
		in_data      = sample_t'(value);
	endtask

	// ten taps, then 64 pixels in raster order, no gaps
	task automatic send_frame();
		for (int k = 0; k < TAPS; k++) begin
			drive_cycle(1'b1, 1'b0, row_tap[k]);
		end
		for (int k = 0; k < TAPS; k++) begin
			drive_cycle(1'b1, 1'b0, col_tap[k]);
		end
		for (int r = 0; r < IMG_DIM; r++) begin
			for (int c = 0; c < IMG_DIM; c++) begin
				drive_cycle(1'b0, 1'b1, pix_mem[r][c]);
			end
		end
		drive_cycle(1'b0, 1'b0, 0);
	endtask

	// uniform over -8..7
	function automatic int rand_sample();
		return int'($urandom_range(15)) - 8;
	endfunction

	function automatic void fill_random_pixels();
		for (int r = 0; r < IMG_DIM; r++) begin
			for (int c = 0; c < IMG_DIM; c++) begin
				pix_mem[r][c] = rand_sample();
			end
		end
	endfunction

	function automatic void fill_random_taps();
		for (int k = 0; k < TAPS; k++) begin
			row_tap[k] = rand_sample();
			col_tap[k] = rand_sample();
		end
	endfunction

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	// row tap k on pixel column c+k, column tap k on row-sum row r+k
	function automatic void build_expected();
		int rs [IMG_DIM][OUT_DIM];
		int acc;
		for (int r = 0; r < IMG_DIM; r++) begin
			for (int c = 0; c < OUT_DIM; c++) begin
				acc = 0;
				for (int k = 0; k < TAPS; k++) begin
					acc += row_tap[k] * pix_mem[r][c+k];
				end
				rs[r][c] = acc;
			end
		end
		for (int r = 0; r < OUT_DIM; r++) begin
			for (int c = 0; c < OUT_DIM; c++) begin
				acc = 0;
				for (int k = 0; k < TAPS; k++) begin
					acc += col_tap[k] * rs[r+k][c];
				end
				exp_res[r*OUT_DIM+c] = result_t'(acc);
			end
		end
	endfunction

	// sampled on the falling edge, away from the flops
	task automatic collect_frame(input string test_name);
		int n;
		int waited;
		n = 0;
		waited = 0;
		@(negedge clk);
		while (!out_valid) begin
			waited++;
			if (waited > START_WAIT) begin
				$display("%s: no result appeared after the frame was sent", test_name);
				stop_with_failure();
			end
			@(negedge clk);
		end
		while (out_valid) begin
			if (n >= OUT_COUNT) begin
				$display("%s: more than %0d results in one frame", test_name, OUT_COUNT);
				stop_with_failure();
			end
			check_result("out_data", exp_res[n], out_data);
			n++;
			@(negedge clk);
		end
		if (n != OUT_COUNT) begin
			$display("%s: got %0d results instead of %0d", test_name, n, OUT_COUNT);
			stop_with_failure();
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic test_idle_after_reset();
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_flag("out_valid", 1'b0, out_valid);
			check_result("out_data", '0, out_data);
		end
	endtask

	// unit tap at k=0 on both passes passes the top-left 4x4 through
	task automatic test_identity();
		fill_random_pixels();
		for (int k = 0; k < TAPS; k++) begin
			row_tap[k] = (k == 0) ? 1 : 0;
			col_tap[k] = (k == 0) ? 1 : 0;
		end
		for (int r = 0; r < OUT_DIM; r++) begin
			for (int c = 0; c < OUT_DIM; c++) begin
				exp_res[r*OUT_DIM+c] = result_t'(pix_mem[r][c]);
			end
		end
		send_frame();
		collect_frame("identity");
	endtask

	task automatic test_random();
		fill_random_taps();
		fill_random_pixels();
		build_expected();
		send_frame();
		collect_frame("random");
	endtask

	// all -8, so each result is 25 products of (-8)^3
	task automatic test_extremes();
		for (int k = 0; k < TAPS; k++) begin
			row_tap[k] = -8;
			col_tap[k] = -8;
		end
		for (int r = 0; r < IMG_DIM; r++) begin
			for (int c = 0; c < IMG_DIM; c++) begin
				pix_mem[r][c] = -8;
			end
		end
		for (int i = 0; i < OUT_COUNT; i++) begin
			exp_res[i] = result_t'(TAPS * TAPS * (-8) * (-8) * (-8));
		end
		send_frame();
		collect_frame("extremes");
	endtask

	// new taps every frame, store must re-arm each time
	task automatic test_back_to_back();
		for (int f = 0; f < 3; f++) begin
			fill_random_taps();
			fill_random_pixels();
			build_expected();
			send_frame();
			collect_frame($sformatf("back_to_back frame %0d", f));
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		filter_valid  = 1'b0;
		image_valid   = 1'b0;
		in_data       = '0;
		void'($urandom(93));
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;

		test_idle_after_reset();
		test_identity();
		test_random();
		test_extremes();
		test_back_to_back();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* files.f */
logic/conv_pkg.sv
logic/filter_tap_loader.sv
logic/horizontal_filter.sv
logic/row_result_store.sv
logic/vertical_filter.sv
logic/conv_top.sv
test/conv_sva.sv
test/conv_tb.sv

/* Makefile */
# Verilator flow for the separable 5x5 convolution engine

TOP := conv_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

# the run may stop with a failing status, the log decides the result
sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** TEST PASSED ***' sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
